/* bus_decode.sv */
`timescale 1ns/1ps

module bus_decode import mmio_6s46_pkg::*; (
  input  logic      clk_en,
  input  logic      memory_write_en,
  input  logic      memory_read_en,
  input  mem_addr_u memory_addr,
  input  nibble_t   memory_write_data,
  output bus_req_t  bus_req
);

  logic [ADDR_W-1:0] addr;
  logic [ADDR_W-1:0] lo_offset;
  logic [ADDR_W-1:0] hi_offset;
  logic              in_lo_window;
  logic              in_hi_window;

  assign addr = memory_addr.linear;

  // Upper window lands right after the lower one in display RAM
  assign lo_offset = addr - DISP_LO_BASE;
  assign hi_offset = addr - DISP_HI_BASE + ADDR_W'(DISP_HALF);

  assign in_lo_window = (addr >= DISP_LO_BASE) && (addr < DISP_LO_BASE + ADDR_W'(DISP_HALF));
  assign in_hi_window = (addr >= DISP_HI_BASE) && (addr < DISP_HI_BASE + ADDR_W'(DISP_HALF));

  always_comb begin
    bus_req.tick   = clk_en;
    bus_req.write  = memory_write_en;
    bus_req.read   = memory_read_en;
    bus_req.offset = memory_addr.io.offset;
    bus_req.wdata  = memory_write_data;
    bus_req.index  = '0;
    if (addr < RAM_END) begin
      bus_req.region = REGION_RAM;
      bus_req.index  = addr[9:0];
    end else if (in_lo_window) begin
      bus_req.region = REGION_DISPLAY;
      bus_req.index  = lo_offset[9:0];
    end else if (in_hi_window) begin
      bus_req.region = REGION_DISPLAY;
      bus_req.index  = hi_offset[9:0];
    end else if (memory_addr.io.page == IO_PAGE) begin
      bus_req.region = REGION_IO;
    end else begin
      bus_req.region = REGION_UNMAPPED;
    end
  end

endmodule

/* clock_timer.sv */
`timescale 1ns/1ps

module clock_timer import mmio_6s46_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        clk_en,
  input  logic        timer_reset,
  output timer_bits_t timer_bits
);

  logic [DIV_W-1:0] divider;
  logic             step;

  always_ff @(posedge clk) begin
    if (!reset_n || timer_reset) begin
      divider    <= '0;
      step       <= 1'b0;
      timer_bits <= '0;
    end else begin
      // Step lands on the cycle after the last tick of the period
      step <= clk_en && (divider == DIV_W'(TICKS_PER_STEP - 1));
      if (clk_en) begin
        divider <= divider + 1'b1;
      end
      if (step) begin
        timer_bits <= timer_bits + 1'b1;
      end
    end
  end

endmodule

/* data_ram.sv */
`timescale 1ns/1ps

module data_ram import mmio_6s46_pkg::*; (
  input  logic     clk,
  input  bus_req_t bus_req,
  output nibble_t  rdata
);

  nibble_t mem [RAM_WORDS];
  logic    write_hit;

  assign write_hit = bus_req.tick && bus_req.write && (bus_req.region == REGION_RAM);

  always_ff @(posedge clk) begin
    if (write_hit) begin
      mem[bus_req.index] <= bus_req.wdata;
    end
  end

  // Only meaningful in the RAM region
  assign rdata = mem[bus_req.index];

endmodule

/* display_ram.sv */
`timescale 1ns/1ps

module display_ram import mmio_6s46_pkg::*; (
  input  logic       clk,
  input  bus_req_t   bus_req,
  output nibble_t    rdata,
  input  logic [7:0] video_addr,
  output nibble_t    video_data
);

  nibble_t mem [DISP_WORDS];
  logic    write_hit;

  assign write_hit = bus_req.tick && bus_req.write && (bus_req.region == REGION_DISPLAY);

  // CPU side, index already folded across both windows
  always_ff @(posedge clk) begin
    if (write_hit) begin
      mem[bus_req.index[7:0]] <= bus_req.wdata;
    end
  end

  assign rdata = mem[bus_req.index[7:0]];

  // Scanner side, one clk of latency
  always_ff @(posedge clk) begin
    if (video_addr < DISP_WORDS) begin
      video_data <= mem[video_addr];
    end else begin
      video_data <= '0;
    end
  end

endmodule

/* input_lines.sv */
`timescale 1ns/1ps

module input_lines import mmio_6s46_pkg::*; (
  input  logic    clk,
  input  logic    reset_n,
  input  logic    clk_en,
  input  nibble_t input_k0,
  input  nibble_t input_k1,
  input  io_cfg_t cfg,
  input  logic    clear_input,
  output logic    k0_factor,
  output logic    k1_factor
);

  nibble_t k0_q;
  nibble_t k1_q;
  nibble_t k0_fall;
  nibble_t k0_rise;
  nibble_t k1_fall;
  logic    k0_hit;
  logic    k1_hit;

  assign k0_fall = k0_q & ~input_k0;
  assign k0_rise = ~k0_q & input_k0;
  assign k1_fall = k1_q & ~input_k1;

  // Relation 1 selects the falling edge, 0 the rising edge
  assign k0_hit = clk_en &&
                  |(cfg.k0_mask & ((cfg.k0_relation & k0_fall) | (~cfg.k0_relation & k0_rise)));
  assign k1_hit = clk_en && |(cfg.k1_mask & k1_fall);

  // Samples track the pins in reset so no false edge follows it
  always_ff @(posedge clk) begin
    if (!reset_n || clk_en) begin
      k0_q <= input_k0;
      k1_q <= input_k1;
    end
  end

  // A new edge beats a clear on the same edge
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      k0_factor <= 1'b0;
      k1_factor <= 1'b0;
    end else begin
      k0_factor <= k0_hit || (k0_factor && !clear_input);
      k1_factor <= k1_hit || (k1_factor && !clear_input);
    end
  end

endmodule

/* interrupt_ctrl.sv */
`timescale 1ns/1ps

module interrupt_ctrl import mmio_6s46_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        clk_en,
  input  timer_bits_t timer_bits,
  input  io_cfg_t     cfg,
  input  logic        clear_clock,
  input  logic        k0_factor,
  input  logic        k1_factor,
  output logic [3:0]  clock_factor,
  output irq_t        interrupt_req
);

  logic [3:0] watched;
  logic [3:0] watched_q;
  logic [3:0] fall;

  // 1, 2, 8 and 32 Hz taps, in factor bit order
  assign watched = {timer_bits[7], timer_bits[6], timer_bits[4], timer_bits[2]};
  assign fall    = clk_en ? (watched_q & ~watched) : 4'b0;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      watched_q    <= '0;
      clock_factor <= '0;
    end else begin
      if (clk_en) begin
        watched_q <= watched;
      end
      // Factors set regardless of mask; set wins over clear
      clock_factor <= fall | (clear_clock ? 4'b0 : clock_factor);
    end
  end

  assign interrupt_req.clock = |(clock_factor & cfg.clock_mask);
  assign interrupt_req.k0    = k0_factor;
  assign interrupt_req.k1    = k1_factor;

endmodule

/* io_regs.sv */
`timescale 1ns/1ps

module io_regs import mmio_6s46_pkg::*; (
  input  logic          clk,
  input  logic          reset_n,
  input  bus_req_t      bus_req,
  input  nibble_t       input_k0,
  input  nibble_t       input_k1,
  input  timer_bits_t   timer_bits,
  input  factor_t       factors,
  output io_cfg_t       cfg,
  output factor_clear_t clear,
  output logic          timer_reset,
  output nibble_t       rdata
);

  logic io_access;
  logic io_write;
  logic io_read;

  assign io_access = bus_req.tick && (bus_req.region == REGION_IO);
  assign io_write  = io_access && bus_req.write;
  assign io_read   = io_access && bus_req.read && !bus_req.write;

  // Software settings
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      cfg.clock_mask  <= '0;
      cfg.k0_mask     <= '0;
      cfg.k1_mask     <= '0;
      cfg.k0_relation <= 4'hF;
    end else if (io_write) begin
      case (bus_req.offset)
        REG_CLK_MASK:    cfg.clock_mask  <= bus_req.wdata;
        REG_K0_MASK:     cfg.k0_mask     <= bus_req.wdata;
        REG_K1_MASK:     cfg.k1_mask     <= bus_req.wdata;
        REG_K0_RELATION: cfg.k0_relation <= bus_req.wdata;
        default: ;
      endcase
    end
  end

  // One-cycle strobes, applied on the following edge
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      timer_reset  <= 1'b0;
      clear.clock  <= 1'b0;
      clear.inputs <= 1'b0;
    end else begin
      timer_reset  <= io_write && (bus_req.offset == REG_TIMER_RESET) && bus_req.wdata[1];
      clear.clock  <= io_read && (bus_req.offset == REG_CLK_FACTOR);
      // Either input factor read clears both
      clear.inputs <= io_read &&
                      ((bus_req.offset == REG_K0_FACTOR) || (bus_req.offset == REG_K1_FACTOR));
    end
  end

  always_comb begin
    case (bus_req.offset)
      REG_CLK_FACTOR:  rdata = factors.clock;
      REG_K0_FACTOR:   rdata = {3'b0, factors.k0};
      REG_K1_FACTOR:   rdata = {3'b0, factors.k1};
      REG_CLK_MASK:    rdata = cfg.clock_mask;
      REG_K0_MASK:     rdata = cfg.k0_mask;
      REG_K1_MASK:     rdata = cfg.k1_mask;
      REG_TIMER_LO:    rdata = timer_bits[3:0];
      REG_TIMER_HI:    rdata = timer_bits[7:4];
      REG_K0_VALUE:    rdata = input_k0;
      REG_K0_RELATION: rdata = cfg.k0_relation;
      REG_K1_VALUE:    rdata = input_k1;
      // Timer reset is write only
      default:         rdata = '0;
    endcase
  end

endmodule

/* mmio_6s46.f */
mmio_6s46_pkg.sv
bus_decode.sv
data_ram.sv
display_ram.sv
clock_timer.sv
input_lines.sv
interrupt_ctrl.sv
io_regs.sv
read_return.sv
mmio_6s46_top.sv
mmio_6s46_tb.sv

/* mmio_6s46_pkg.sv */
package mmio_6s46_pkg;

  // Bus widths
  localparam int ADDR_W = 12;
  localparam int NIB_W  = 4;

  // Address map
  localparam int                RAM_WORDS    = 640;
  localparam logic [ADDR_W-1:0] RAM_END      = 12'h280;
  localparam int                DISP_WORDS   = 160;
  localparam int                DISP_HALF    = 80;
  localparam logic [ADDR_W-1:0] DISP_LO_BASE = 12'hE00;
  localparam logic [ADDR_W-1:0] DISP_HI_BASE = 12'hE80;
  localparam logic [3:0]        IO_PAGE      = 4'hF;

  // 256 Hz timer step from a 32768 Hz tick
  localparam int TICKS_PER_STEP = 128;
  localparam int DIV_W          = $clog2(TICKS_PER_STEP);

  // I/O page register offsets
  localparam logic [7:0] REG_CLK_FACTOR  = 8'h00;
  localparam logic [7:0] REG_K0_FACTOR   = 8'h04;
  localparam logic [7:0] REG_K1_FACTOR   = 8'h05;
  localparam logic [7:0] REG_CLK_MASK    = 8'h10;
  localparam logic [7:0] REG_K0_MASK     = 8'h14;
  localparam logic [7:0] REG_K1_MASK     = 8'h15;
  localparam logic [7:0] REG_TIMER_LO    = 8'h20;
  localparam logic [7:0] REG_TIMER_HI    = 8'h21;
  localparam logic [7:0] REG_K0_VALUE    = 8'h40;
  localparam logic [7:0] REG_K0_RELATION = 8'h41;
  localparam logic [7:0] REG_K1_VALUE    = 8'h42;
  localparam logic [7:0] REG_TIMER_RESET = 8'h76;

  typedef logic [NIB_W-1:0] nibble_t;

  typedef struct packed {
    logic [3:0] page;
    logic [7:0] offset;
  } io_addr_t;

  // Same bus address, seen linearly or as page plus register
  typedef union packed {
    logic [ADDR_W-1:0] linear;
    io_addr_t          io;
  } mem_addr_u;

  typedef enum logic [1:0] {
    REGION_RAM,
    REGION_DISPLAY,
    REGION_IO,
    REGION_UNMAPPED
  } region_e;

  typedef struct packed {
    logic       tick;
    logic       write;
    logic       read;
    region_e    region;
    logic [9:0] index;
    logic [7:0] offset;
    nibble_t    wdata;
  } bus_req_t;

  // Bit 0 is 128 Hz, bit 7 is 1 Hz
  typedef logic [7:0] timer_bits_t;

  typedef struct packed {
    logic [3:0] clock_mask;
    logic [3:0] k0_mask;
    logic [3:0] k1_mask;
    logic [3:0] k0_relation;
  } io_cfg_t;

  // Clock factor bits 0..3 are 32, 8, 2 and 1 Hz
  typedef struct packed {
    logic [3:0] clock;
    logic       k0;
    logic       k1;
  } factor_t;

  typedef struct packed {
    logic clock;
    logic inputs;
  } factor_clear_t;

  typedef struct packed {
    logic clock;
    logic k0;
    logic k1;
  } irq_t;

endpackage

/* mmio_6s46_tb.sv */
`timescale 1ns/1ps

module mmio_6s46_tb import mmio_6s46_pkg::*; ();

  logic       clk;
  logic       reset_n;
  logic       clk_en;
  logic       memory_write_en;
  logic       memory_read_en;
  mem_addr_u  memory_addr;
  nibble_t    memory_write_data;
  nibble_t    memory_read_data;
  nibble_t    input_k0;
  nibble_t    input_k1;
  logic [7:0] video_addr;
  nibble_t    video_data;
  irq_t       interrupt_req;

  // Reference model
  nibble_t     ram_model [RAM_WORDS];
  nibble_t     disp_model [DISP_WORDS];
  nibble_t     clock_mask_model;
  nibble_t     k0_mask_model;
  nibble_t     k1_mask_model;
  nibble_t     relation_model;
  int          tick_count;
  int          access_ticks;
  int          timer_ref;
  logic [11:0] written [$];

  integer seed;
  int     checks;
  int     errors;
  int     timeouts;

  mmio_6s46_top u_dut (
    .clk               (clk),
    .reset_n           (reset_n),
    .clk_en            (clk_en),
    .memory_write_en   (memory_write_en),
    .memory_read_en    (memory_read_en),
    .memory_addr       (memory_addr),
    .memory_write_data (memory_write_data),
    .memory_read_data  (memory_read_data),
    .input_k0          (input_k0),
    .input_k1          (input_k1),
    .video_addr        (video_addr),
    .video_data        (video_data),
    .interrupt_req     (interrupt_req)
  );

  always #5 clk = ~clk;

  // Ticks as the DUT sees them
  always @(posedge clk) begin
    if (!reset_n) begin
      tick_count <= 0;
    end else if (clk_en) begin
      tick_count <= tick_count + 1;
    end
  end

  assert property (@(posedge clk) disable iff (!reset_n)
    (clk_en && !memory_read_en && !memory_write_en) |=> (memory_read_data == 4'h0))
    else begin
      errors++;
      $display("ERR %0t: read data %h after an idle tick", $time, memory_read_data);
    end

  assert property (@(posedge clk) disable iff (!reset_n)
    interrupt_req.clock |-> (clock_mask_model != 4'h0))
    else begin
      errors++;
      $display("ERR %0t: clock request with all clock mask bits clear", $time);
    end

  assert property (@(posedge clk) disable iff (!reset_n)
    (video_addr >= 8'd160) |=> (video_data == 4'h0))
    else begin
      errors++;
      $display("ERR %0t: video data %h outside the display array", $time, video_data);
    end

  function automatic logic draw_tick();
    return ($random(seed) & 3) != 0;
  endfunction

  // Display slot of a window address, -1 outside both windows
  function automatic int disp_index(logic [11:0] addr);
    if (addr >= 12'hE00 && addr < 12'hE50) return int'(addr - 12'hE00);
    if (addr >= 12'hE80 && addr < 12'hED0) return int'(addr - 12'hE80) + DISP_HALF;
    return -1;
  endfunction

  function automatic void model_write(logic [11:0] addr, nibble_t data);
    int di;
    di = disp_index(addr);
    if (addr < RAM_END) ram_model[addr[9:0]] = data;
    else if (di >= 0) disp_model[di] = data;
    else if (addr == {IO_PAGE, REG_CLK_MASK}) clock_mask_model = data;
    else if (addr == {IO_PAGE, REG_K0_MASK}) k0_mask_model = data;
    else if (addr == {IO_PAGE, REG_K1_MASK}) k1_mask_model = data;
    else if (addr == {IO_PAGE, REG_K0_RELATION}) relation_model = data;
    else if (addr == {IO_PAGE, REG_TIMER_RESET} && data[1]) timer_ref = access_ticks;
  endfunction

  function automatic nibble_t model_read(logic [11:0] addr);
    int di;
    di = disp_index(addr);
    if (addr < RAM_END) return ram_model[addr[9:0]];
    if (di >= 0) return disp_model[di];
    if (addr == {IO_PAGE, REG_CLK_MASK}) return clock_mask_model;
    if (addr == {IO_PAGE, REG_K0_MASK}) return k0_mask_model;
    if (addr == {IO_PAGE, REG_K1_MASK}) return k1_mask_model;
    if (addr == {IO_PAGE, REG_K0_RELATION}) return relation_model;
    return 4'h0;
  endfunction

  // Timer nibble within one step of the model count
  function automatic logic count_matches(nibble_t got, int steps, int shift);
    logic ok;
    int   cand;
    ok = 1'b0;
    for (int d = -1; d <= 1; d++) begin
      cand = ((steps + d) >> shift) & 15;
      if (got == cand[3:0]) ok = 1'b1;
    end
    return ok;
  endfunction

  task automatic check_value(input nibble_t got, input nibble_t exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    clk_en          <= draw_tick();
    memory_write_en <= 1'b0;
    memory_read_en  <= 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) idle_cycle();
  endtask

  task automatic idle_ticks(input int n);
    int start;
    int cycles;
    start  = tick_count;
    cycles = 0;
    while ((tick_count - start) < n && cycles < 4 * n + 16) begin
      idle_cycle();
      cycles++;
    end
    if ((tick_count - start) < n) begin
      timeouts++;
      $display("Timed out waiting for %0d clock enable ticks", n);
    end
  endtask

  // Holds the access until a tick carries it, result sampled mid cycle
  task automatic bus_access(input logic wr, input logic [11:0] addr, input nibble_t wdata,
                            output nibble_t rdata);
    logic tick;
    int   tries;
    tick  = 1'b0;
    tries = 0;
    while (!tick && tries < 64) begin
      @(posedge clk);
      tick = draw_tick();
      clk_en               <= tick;
      memory_addr.linear   <= addr;
      memory_write_en      <= wr;
      memory_read_en       <= !wr;
      memory_write_data    <= wdata;
      tries++;
    end
    @(posedge clk);
    access_ticks = tick_count;
    clk_en          <= 1'b0;
    memory_write_en <= 1'b0;
    memory_read_en  <= 1'b0;
    @(negedge clk);
    rdata = memory_read_data;
    if (!tick) begin
      timeouts++;
      $display("Timed out waiting for a clock enable tick to access %h", addr);
    end
  endtask

  task automatic write_bus(input logic [11:0] addr, input nibble_t data);
    nibble_t unused;
    bus_access(1'b1, addr, data, unused);
    model_write(addr, data);
  endtask

  task automatic read_expect(input logic [11:0] addr, input nibble_t exp);
    nibble_t got;
    bus_access(1'b0, addr, 4'h0, got);
    check_value(got, exp, $sformatf("read of %h", addr));
  endtask

  task automatic video_expect(input int a, input nibble_t exp);
    @(posedge clk);
    video_addr <= 8'(a);
    @(posedge clk);
    @(negedge clk);
    check_value(video_data, exp, $sformatf("video data at %0d", a));
  endtask

  task automatic wait_irq(input logic [2:0] want, input int tick_limit, input string name);
    int   start;
    int   cycles;
    logic seen;
    start  = tick_count;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && (tick_count - start) <= tick_limit && cycles < 4 * tick_limit + 16) begin
      idle_cycle();
      @(negedge clk);
      seen = |(interrupt_req & want);
      cycles++;
    end
    if (!seen) begin
      timeouts++;
      $display("Timed out waiting for the %s interrupt request", name);
    end
  endtask

  task automatic check_timer();
    nibble_t lo;
    nibble_t hi;
    int      steps;
    bus_access(1'b0, {IO_PAGE, REG_TIMER_LO}, 4'h0, lo);
    steps = (access_ticks - timer_ref) / TICKS_PER_STEP;
    checks++;
    assert (count_matches(lo, steps, 0)) else begin
      errors++;
      $display("ERR %0t: timer low nibble %h, model at %0d steps", $time, lo, steps);
    end
    bus_access(1'b0, {IO_PAGE, REG_TIMER_HI}, 4'h0, hi);
    steps = (access_ticks - timer_ref) / TICKS_PER_STEP;
    checks++;
    assert (count_matches(hi, steps, 4)) else begin
      errors++;
      $display("ERR %0t: timer high nibble %h, model at %0d steps", $time, hi, steps);
    end
  endtask

  task automatic drive_pins(input nibble_t k0, input nibble_t k1);
    @(posedge clk);
    input_k0 <= k0;
    input_k1 <= k1;
  endtask

  initial begin
    int          n;
    logic [11:0] addr;
    nibble_t     got;
    seed              = 32'h9e06;
    clk               = 1'b0;
    reset_n           = 1'b0;
    clk_en            = 1'b0;
    memory_write_en   = 1'b0;
    memory_read_en    = 1'b0;
    memory_addr       = '0;
    memory_write_data = '0;
    input_k0          = 4'hF;
    input_k1          = 4'hF;
    video_addr        = '0;
    clock_mask_model  = 4'h0;
    k0_mask_model     = 4'h0;
    k1_mask_model     = 4'h0;
    relation_model    = 4'hF;
    checks            = 0;
    errors            = 0;
    timeouts          = 0;
    timer_ref         = 0;
    access_ticks      = 0;
    repeat (10) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);

    // Reset state
    check_value(memory_read_data, 4'h0, "read data after reset");
    check_value({1'b0, interrupt_req}, 4'h0, "interrupt requests after reset");
    read_expect({IO_PAGE, REG_CLK_MASK}, 4'h0);
    read_expect({IO_PAGE, REG_K0_MASK}, 4'h0);
    read_expect({IO_PAGE, REG_K1_MASK}, 4'h0);
    read_expect({IO_PAGE, REG_K0_RELATION}, 4'hF);

    // Data RAM with reads of earlier writes
    for (int i = 0; i < 48; i++) begin
      addr = 12'($unsigned($random(seed)) % RAM_WORDS);
      write_bus(addr, 4'($random(seed)));
      written.push_back(addr);
      if (i % 3 == 2) begin
        addr = written[$unsigned($random(seed)) % written.size()];
        read_expect(addr, model_read(addr));
        idle(2);
      end
    end
    // Nonzero data behind the slots a wrong decode would reach
    write_bus(12'h000, 4'h5);
    write_bus(12'hE80, 4'hA);
    read_expect(12'h300, 4'h0);
    read_expect(12'hE50, 4'h0);

    // Display windows and the video port
    for (int i = 0; i < 6; i++) begin
      n = (i == 0) ? 0 : (i == 1) ? DISP_HALF - 1 : $unsigned($random(seed)) % DISP_HALF;
      write_bus(12'hE00 + 12'(n), 4'($random(seed)));
      write_bus(12'hE80 + 12'(n), 4'($random(seed)));
      read_expect(12'hE00 + 12'(n), model_read(12'hE00 + 12'(n)));
      read_expect(12'hE80 + 12'(n), model_read(12'hE80 + 12'(n)));
      video_expect(n, disp_model[n]);
      video_expect(n + DISP_HALF, disp_model[n + DISP_HALF]);
    end
    video_expect(160, 4'h0);
    video_expect(255, 4'h0);

    // Clock timer from its reset
    write_bus({IO_PAGE, REG_TIMER_RESET}, 4'h2);
    idle_ticks(600);
    check_timer();
    idle_ticks(2500);
    check_timer();

    // 32 Hz clock interrupt, masked and unmasked
    bus_access(1'b0, {IO_PAGE, REG_CLK_FACTOR}, 4'h0, got);
    write_bus({IO_PAGE, REG_CLK_MASK}, 4'h1);
    wait_irq(3'b100, 2 * 8 * TICKS_PER_STEP, "clock");
    bus_access(1'b0, {IO_PAGE, REG_CLK_FACTOR}, 4'h0, got);
    check_value(got & 4'h1, 4'h1, "32 Hz clock factor");
    idle(2);
    @(negedge clk);
    check_value({3'b0, interrupt_req.clock}, 4'h0, "clock request after factor read");
    write_bus({IO_PAGE, REG_CLK_MASK}, 4'h0);
    bus_access(1'b0, {IO_PAGE, REG_CLK_FACTOR}, 4'h0, got);
    idle_ticks(8 * TICKS_PER_STEP + 64);
    @(negedge clk);
    check_value({3'b0, interrupt_req.clock}, 4'h0, "clock request with mask clear");
    bus_access(1'b0, {IO_PAGE, REG_CLK_FACTOR}, 4'h0, got);
    check_value(got & 4'h1, 4'h1, "32 Hz factor with mask clear");

    // Input ports K0 and K1
    write_bus({IO_PAGE, REG_K0_MASK}, 4'h1);
    write_bus({IO_PAGE, REG_K1_MASK}, 4'h2);
    drive_pins(4'hE, 4'hF);
    wait_irq(3'b010, 8, "K0 falling edge");
    drive_pins(4'hE, 4'hD);
    wait_irq(3'b001, 8, "K1");
    read_expect({IO_PAGE, REG_K0_VALUE}, 4'hE);
    read_expect({IO_PAGE, REG_K1_VALUE}, 4'hD);
    read_expect({IO_PAGE, REG_K0_FACTOR}, 4'h1);
    idle(2);
    @(negedge clk);
    check_value({1'b0, interrupt_req}, 4'h0, "requests after input factor read");
    // Relation 0 turns K0 to the rising edge
    write_bus({IO_PAGE, REG_K0_RELATION}, 4'h0);
    drive_pins(4'hF, 4'hD);
    wait_irq(3'b010, 8, "K0 rising edge");
    read_expect({IO_PAGE, REG_K1_FACTOR}, 4'h0);
    idle(2);
    @(negedge clk);
    check_value({3'b0, interrupt_req.k0}, 4'h0, "K0 request after K1 factor read");

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* mmio_6s46_top.sv */
`timescale 1ns/1ps

module mmio_6s46_top import mmio_6s46_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  logic      clk_en,
  input  logic      memory_write_en,
  input  logic      memory_read_en,
  input  mem_addr_u memory_addr,
  input  nibble_t   memory_write_data,
  output nibble_t   memory_read_data,
  input  nibble_t   input_k0,
  input  nibble_t   input_k1,
  input  logic [7:0] video_addr,
  output nibble_t   video_data,
  output irq_t      interrupt_req
);

  bus_req_t      bus_req;
  nibble_t       ram_rdata;
  nibble_t       disp_rdata;
  nibble_t       io_rdata;
  io_cfg_t       cfg;
  factor_clear_t clear;
  logic          timer_reset;
  timer_bits_t   timer_bits;
  logic          k0_factor;
  logic          k1_factor;
  logic [3:0]    clock_factor;
  factor_t       factors;

  assign factors = '{clock: clock_factor, k0: k0_factor, k1: k1_factor};

  // Input side
  bus_decode u_bus_decode (
    .clk_en            (clk_en),
    .memory_write_en   (memory_write_en),
    .memory_read_en    (memory_read_en),
    .memory_addr       (memory_addr),
    .memory_write_data (memory_write_data),
    .bus_req           (bus_req)
  );

  input_lines u_input_lines (
    .clk         (clk),
    .reset_n     (reset_n),
    .clk_en      (clk_en),
    .input_k0    (input_k0),
    .input_k1    (input_k1),
    .cfg         (cfg),
    .clear_input (clear.inputs),
    .k0_factor   (k0_factor),
    .k1_factor   (k1_factor)
  );

  // Storage and timing
  data_ram u_data_ram (
    .clk     (clk),
    .bus_req (bus_req),
    .rdata   (ram_rdata)
  );

  display_ram u_display_ram (
    .clk        (clk),
    .bus_req    (bus_req),
    .rdata      (disp_rdata),
    .video_addr (video_addr),
    .video_data (video_data)
  );

  clock_timer u_clock_timer (
    .clk         (clk),
    .reset_n     (reset_n),
    .clk_en      (clk_en),
    .timer_reset (timer_reset),
    .timer_bits  (timer_bits)
  );

  interrupt_ctrl u_interrupt_ctrl (
    .clk           (clk),
    .reset_n       (reset_n),
    .clk_en        (clk_en),
    .timer_bits    (timer_bits),
    .cfg           (cfg),
    .clear_clock   (clear.clock),
    .k0_factor     (k0_factor),
    .k1_factor     (k1_factor),
    .clock_factor  (clock_factor),
    .interrupt_req (interrupt_req)
  );

  io_regs u_io_regs (
    .clk         (clk),
    .reset_n     (reset_n),
    .bus_req     (bus_req),
    .input_k0    (input_k0),
    .input_k1    (input_k1),
    .timer_bits  (timer_bits),
    .factors     (factors),
    .cfg         (cfg),
    .clear       (clear),
    .timer_reset (timer_reset),
    .rdata       (io_rdata)
  );

  // Output side
  read_return u_read_return (
    .clk              (clk),
    .reset_n          (reset_n),
    .bus_req          (bus_req),
    .ram_rdata        (ram_rdata),
    .disp_rdata       (disp_rdata),
    .io_rdata         (io_rdata),
    .memory_read_data (memory_read_data)
  );

endmodule

/* read_return.sv */
`timescale 1ns/1ps

module read_return import mmio_6s46_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  input  bus_req_t bus_req,
  input  nibble_t  ram_rdata,
  input  nibble_t  disp_rdata,
  input  nibble_t  io_rdata,
  output nibble_t  memory_read_data
);

  nibble_t selected;

  always_comb begin
    case (bus_req.region)
      REGION_RAM:     selected = ram_rdata;
      REGION_DISPLAY: selected = disp_rdata;
      REGION_IO:      selected = io_rdata;
      default:        selected = '0;
    endcase
  end

  // Writes hold the last value; idle ticks return zero
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      memory_read_data <= '0;
    end else if (bus_req.tick && !bus_req.write) begin
      memory_read_data <= bus_req.read ? selected : '0;
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module mmio_6s46_tb -f mmio_6s46.f &&
./obj_dir/Vmmio_6s46_tb > sim.log 2>&1
grep -q "^Everything OK$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
